// ==== i2c_pkg.sv ====
//####################################################################
// I2C master shared definitions
// Register map, control and status bits, FSM states, byte commands
//####################################################################
`default_nettype none

package i2c_pkg;

    // SCL period is 4 * prescaler clk cycles
    localparam int prescaler   = 4;
    localparam int presc_width = (prescaler > 1) ? $clog2(prescaler) : 1;

    // Register addresses on the 16-bit bus
    typedef enum logic [2:0] {
        REG_CONTROL = 3'd0,
        REG_STATUS  = 3'd1,
        REG_INTFLAG = 3'd2,
        REG_DADDR   = 3'd3,
        REG_IADDR   = 3'd4,
        REG_TXDATA  = 3'd5,
        REG_RXDATA  = 3'd6
    } reg_addr_e;

    // CONTROL fields
    localparam int ctl_start_bit  = 1;
    localparam int ctl_dir_bit    = 2;   // 0 write, 1 read
    localparam int ctl_iaddr_bit  = 6;   // One byte internal address
    localparam int ctl_length_bit = 8;   // Byte count minus one

    // STATUS fields
    localparam int stat_busy_bit = 0;
    localparam int stat_ack_bit  = 1;

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_DEVADDR,
        S_INTADDR,
        S_WRITE,
        S_RESTART,
        S_RD_DEVADDR,
        S_READ,
        S_STOP
    } seq_state_e;

    typedef enum logic [1:0] {
        CMD_BYTE,
        CMD_START,
        CMD_RESTART,
        CMD_STOP
    } byte_cmd_e;

endpackage

`default_nettype wire

// ==== i2c_regs.sv ====
//####################################################################
// I2C master register file
// Bus decode, transfer configuration, RXDATA and the COMPLETE flag
//####################################################################
`default_nettype none

module i2c_regs import i2c_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire  [2:0]  bus_address,
    input  wire         bus_read,
    input  wire         bus_write,
    input  wire  [15:0] bus_writedata,
    output logic [15:0] bus_readdata,
    output logic        irq,
    output logic        go,
    output logic        dir,
    output logic        iaddr_en,
    output logic        length,
    output logic [6:0]  dev_addr,
    output logic [7:0]  int_addr,
    output logic [7:0]  tx_byte0,
    output logic [7:0]  tx_byte1,
    input  wire         busy,
    input  wire         ack,
    input  wire         complete,
    input  wire         rx_strobe,
    input  wire         rx_index,
    input  wire  [7:0]  rx_byte
);

    logic [7:0]  rx0;
    logic [7:0]  rx1;
    logic        complete_flag;
    logic [15:0] status_word;

    always_comb begin
        status_word = '0;
        status_word[stat_busy_bit] = busy;
        status_word[stat_ack_bit]  = ack;
    end

    assign irq = complete_flag;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bus_readdata  <= '0;
            go            <= 1'b0;
            dir           <= 1'b0;
            iaddr_en      <= 1'b0;
            length        <= 1'b0;
            dev_addr      <= '0;
            int_addr      <= '0;
            tx_byte0      <= '0;
            tx_byte1      <= '0;
            rx0           <= '0;
            rx1           <= '0;
            complete_flag <= 1'b0;
        end else begin
            go <= 1'b0;
            complete_flag <= complete_flag | complete;

            if (rx_strobe) begin
                if (rx_index) rx1 <= rx_byte;
                else          rx0 <= rx_byte;
            end

            if (bus_read) begin
                case (bus_address)
                    REG_STATUS:  bus_readdata <= status_word;
                    REG_INTFLAG: bus_readdata <= {15'd0, complete_flag};
                    REG_RXDATA:  bus_readdata <= {rx1, rx0};
                    default:     bus_readdata <= 16'h0000;  // Write-only registers
                endcase
            end

            if (bus_write) begin
                case (bus_address)
                    REG_CONTROL: begin
                        // Ignored while a transfer runs
                        if (!busy) begin
                            go       <= bus_writedata[ctl_start_bit];
                            dir      <= bus_writedata[ctl_dir_bit];
                            iaddr_en <= bus_writedata[ctl_iaddr_bit];
                            length   <= bus_writedata[ctl_length_bit];
                        end
                    end
                    REG_INTFLAG: complete_flag <= 1'b0;  // Any value clears
                    REG_DADDR:   dev_addr <= bus_writedata[6:0];
                    REG_IADDR:   int_addr <= bus_writedata[7:0];
                    REG_TXDATA: begin
                        tx_byte0 <= bus_writedata[7:0];
                        tx_byte1 <= bus_writedata[15:8];
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== i2c_sequencer.sv ====
//####################################################################
// I2C transfer sequencer
// Turns a START request into START, address, data and STOP commands
//####################################################################
`default_nettype none

module i2c_sequencer import i2c_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire        go,
    input  wire        dir,
    input  wire        iaddr_en,
    input  wire        length,
    input  wire  [6:0] dev_addr,
    input  wire  [7:0] int_addr,
    input  wire  [7:0] tx_byte0,
    input  wire  [7:0] tx_byte1,
    output logic       busy,
    output logic       ack,
    output logic       complete,
    output logic       rx_strobe,
    output logic       rx_index,
    output logic [7:0] rx_byte,
    output logic       cmd_valid,
    output byte_cmd_e  cmd,
    output logic [7:0] cmd_data,
    output logic       cmd_ack,
    input  wire        cmd_ready,
    input  wire        done,
    input  wire  [7:0] done_data,
    input  wire        done_ack
);

    seq_state_e state;
    logic       count;    // Data byte index
    logic       issued;   // Command of this state already sent
    logic       more;     // Another data byte follows

    assign more = (count == 1'b0) && length;
    assign busy = (state != S_IDLE);

    // Received bytes go straight to RXDATA
    assign rx_strobe = done && (state == S_READ);
    assign rx_index  = count;
    assign rx_byte   = done_data;

    // Command fields follow the state, the engine latches them on acceptance
    always_comb begin
        cmd      = CMD_BYTE;
        cmd_data = 8'hff;
        cmd_ack  = 1'b0;
        case (state)
            S_START:      cmd = CMD_START;
            S_DEVADDR:    cmd_data = {dev_addr, dir & ~iaddr_en};  // R/W bit only without iaddr
            S_INTADDR:    cmd_data = int_addr;
            S_WRITE:      cmd_data = count ? tx_byte1 : tx_byte0;
            S_RESTART:    cmd = CMD_RESTART;
            S_RD_DEVADDR: cmd_data = {dev_addr, 1'b1};
            S_READ:       cmd_ack = more;  // NACK on the last byte
            S_STOP:       cmd = CMD_STOP;
            default:      cmd = CMD_BYTE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= S_IDLE;
            count     <= 1'b0;
            issued    <= 1'b0;
            ack       <= 1'b0;
            complete  <= 1'b0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            complete  <= 1'b0;

            if (state == S_IDLE) begin
                issued <= 1'b0;
                count  <= 1'b0;
                if (go) begin
                    state <= S_START;
                end
            end else if (done) begin
                issued <= 1'b0;
                case (state)
                    S_START: state <= S_DEVADDR;
                    S_DEVADDR: begin
                        ack <= done_ack;
                        if (!done_ack)     state <= S_STOP;
                        else if (iaddr_en) state <= S_INTADDR;
                        else if (dir)      state <= S_READ;
                        else               state <= S_WRITE;
                    end
                    S_INTADDR: begin
                        ack <= done_ack;
                        if (!done_ack) state <= S_STOP;
                        else if (dir)  state <= S_RESTART;
                        else           state <= S_WRITE;
                    end
                    S_WRITE: begin
                        ack <= done_ack;
                        if (done_ack && more) begin
                            count <= 1'b1;
                        end else begin
                            state <= S_STOP;
                        end
                    end
                    S_RESTART: state <= S_RD_DEVADDR;
                    S_RD_DEVADDR: begin
                        ack   <= done_ack;
                        state <= done_ack ? S_READ : S_STOP;
                    end
                    S_READ: begin
                        if (more) count <= 1'b1;
                        else      state <= S_STOP;
                    end
                    S_STOP: begin
                        state    <= S_IDLE;
                        complete <= 1'b1;  // Same edge as busy falling
                    end
                    default: state <= S_IDLE;
                endcase
            end else if (!issued && cmd_ready) begin
                cmd_valid <= 1'b1;  // One command per state
                issued    <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== i2c_byte_engine.sv ====
//####################################################################
// I2C byte engine
// Shifts one byte plus acknowledge, or one START, RESTART or STOP
//####################################################################
`default_nettype none

module i2c_byte_engine import i2c_pkg::*; (
    input  wire            clk,
    input  wire            reset,
    input  wire            cmd_valid,
    input  wire byte_cmd_e cmd,
    input  wire      [7:0] cmd_data,
    input  wire            cmd_ack,
    output logic           cmd_ready,
    output logic           done,
    output logic     [7:0] done_data,
    output logic           done_ack,
    output logic           active,
    output logic           scl_first,
    output logic           scl_last,
    output logic           sda_first,
    output logic           sda_last,
    input  wire            bit_end,
    input  wire            sda_sample
);

    logic [8:0] shreg;    // Bits still to send, then the sampled bits
    logic [3:0] slots;    // Bit slots left
    logic       accept;

    assign accept    = cmd_valid && cmd_ready;
    assign cmd_ready = ~active;
    assign done_data = shreg[8:1];
    assign done_ack  = ~shreg[0];  // Low SDA in slot nine is ACK

    // Bit 7 goes out at once, the rest and the ACK bit wait here
    always_ff @(posedge clk) begin
        if (accept) begin
            shreg <= {cmd_data[6:0], ~cmd_ack, 1'b1};
        end else if (active && bit_end) begin
            shreg <= {shreg[7:0], sda_sample};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active    <= 1'b0;
            done      <= 1'b0;
            slots     <= '0;
            scl_first <= 1'b1;
            scl_last  <= 1'b1;
            sda_first <= 1'b1;
            sda_last  <= 1'b1;
        end else begin
            done <= 1'b0;
            if (accept) begin
                active <= 1'b1;
                case (cmd)
                    CMD_START: begin
                        // SDA falls with SCL high, then SCL low
                        slots     <= 4'd1;
                        scl_first <= 1'b1;
                        scl_last  <= 1'b0;
                        sda_first <= 1'b1;
                        sda_last  <= 1'b0;
                    end
                    CMD_RESTART: begin
                        slots     <= 4'd1;
                        scl_first <= 1'b0;   // SCL still low from the ACK slot
                        scl_last  <= 1'b0;
                        sda_first <= 1'b1;
                        sda_last  <= 1'b0;
                    end
                    CMD_STOP: begin
                        // SDA rises with SCL high, bus left idle
                        slots     <= 4'd1;
                        scl_first <= 1'b0;
                        scl_last  <= 1'b1;
                        sda_first <= 1'b0;
                        sda_last  <= 1'b1;
                    end
                    default: begin
                        slots     <= 4'd9;
                        scl_first <= 1'b0;
                        scl_last  <= 1'b0;
                        sda_first <= cmd_data[7];
                        sda_last  <= cmd_data[7];
                    end
                endcase
            end else if (active && bit_end) begin
                slots <= slots - 4'd1;
                if (slots == 4'd1) begin
                    active <= 1'b0;
                    done   <= 1'b1;
                end else begin
                    sda_first <= shreg[8];
                    sda_last  <= shreg[8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== i2c_bit_timer.sv ====
//####################################################################
// I2C bit timer
// Quarter-bit phases, open-drain pin drive and SDA sampling
//####################################################################
`default_nettype none

module i2c_bit_timer import i2c_pkg::*; (
    input  wire  clk,
    input  wire  reset,
    input  wire  active,
    input  wire  scl_first,
    input  wire  scl_last,
    input  wire  sda_first,
    input  wire  sda_last,
    output logic bit_end,
    output logic sda_sample,
    input  wire  sda_in,
    output logic scl_oe,
    output logic sda_oe
);

    logic [presc_width-1:0] presc;
    logic [1:0]             phase;
    logic                   tick;   // Last clk of a quarter

    assign tick    = active && (presc == presc_width'(prescaler - 1));
    assign bit_end = tick && (phase == 2'd3);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            presc <= '0;
            phase <= '0;
        end else if (!active) begin
            presc <= '0;
            phase <= '0;
        end else if (tick) begin
            presc <= '0;
            phase <= phase + 2'd1;  // Wraps into the next slot
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // Lines hold their last level between commands
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            scl_oe     <= 1'b0;
            sda_oe     <= 1'b0;
            sda_sample <= 1'b1;
        end else begin
            if (active) begin
                case (phase)
                    2'd0:    scl_oe <= ~scl_first;
                    2'd3:    scl_oe <= ~scl_last;
                    default: scl_oe <= 1'b0;  // SCL released in the middle
                endcase
                sda_oe <= phase[1] ? ~sda_last : ~sda_first;
            end
            if (tick && (phase == 2'd2)) begin
                sda_sample <= sda_in;
            end
        end
    end

endmodule

`default_nettype wire

// ==== i2c_master.sv ====
//####################################################################
// I2C master top
// Register file, sequencer, byte engine and bit timer
//####################################################################
`default_nettype none

module i2c_master import i2c_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire  [2:0]  bus_address,
    input  wire         bus_read,
    output logic [15:0] bus_readdata,
    input  wire         bus_write,
    input  wire  [15:0] bus_writedata,
    output logic        irq,
    input  wire         sda_in,
    output logic        scl_oe,
    output logic        sda_oe
);

    // Register file to sequencer
    logic       go;
    logic       dir;
    logic       iaddr_en;
    logic       length;
    logic [6:0] dev_addr;
    logic [7:0] int_addr;
    logic [7:0] tx_byte0;
    logic [7:0] tx_byte1;
    logic       busy;
    logic       ack;
    logic       complete;
    logic       rx_strobe;
    logic       rx_index;
    logic [7:0] rx_byte;

    // Sequencer to byte engine
    logic       cmd_valid;
    byte_cmd_e  cmd;
    logic [7:0] cmd_data;
    logic       cmd_ack;
    logic       cmd_ready;
    logic       done;
    logic [7:0] done_data;
    logic       done_ack;

    // Byte engine to bit timer
    logic active;
    logic scl_first;
    logic scl_last;
    logic sda_first;
    logic sda_last;
    logic bit_end;
    logic sda_sample;

    i2c_regs u_regs (
        .clk, .reset, .bus_address, .bus_read, .bus_write, .bus_writedata,
        .bus_readdata, .irq, .go, .dir, .iaddr_en, .length, .dev_addr,
        .int_addr, .tx_byte0, .tx_byte1, .busy, .ack, .complete,
        .rx_strobe, .rx_index, .rx_byte
    );

    i2c_sequencer u_sequencer (
        .clk, .reset, .go, .dir, .iaddr_en, .length, .dev_addr, .int_addr,
        .tx_byte0, .tx_byte1, .busy, .ack, .complete, .rx_strobe, .rx_index,
        .rx_byte, .cmd_valid, .cmd, .cmd_data, .cmd_ack, .cmd_ready, .done,
        .done_data, .done_ack
    );

    i2c_byte_engine u_byte_engine (
        .clk, .reset, .cmd_valid, .cmd, .cmd_data, .cmd_ack, .cmd_ready,
        .done, .done_data, .done_ack, .active, .scl_first, .scl_last,
        .sda_first, .sda_last, .bit_end, .sda_sample
    );

    i2c_bit_timer u_bit_timer (
        .clk, .reset, .active, .scl_first, .scl_last, .sda_first, .sda_last,
        .bit_end, .sda_sample, .sda_in, .scl_oe, .sda_oe
    );

endmodule

`default_nettype wire

// ==== i2c_slave_model.sv ====
//####################################################################
// I2C target model for the testbench
// 256-byte memory behind a pointer that counts up on every access
//####################################################################
`default_nettype none

module i2c_slave_model (
    input  wire       clk,
    input  wire       reset,
    input  wire [6:0] dev_address,
    input  wire       scl,
    input  wire       sda,
    output logic      sda_pull     // 1 pulls SDA low
);

    logic [7:0] mem [0:255];
    logic [7:0] ptr;
    logic [7:0] shift;        // Bits seen on the bus
    logic [7:0] out_byte;     // Byte being returned
    logic [3:0] bitcnt;       // SCL rising edges in this byte
    logic       scl_q;
    logic       sda_q;
    logic       selected;     // Between START and the end of our part
    logic       got_addr;
    logic       reading;
    logic       sending;
    logic       first;        // Next written byte loads the pointer
    logic       master_ack;

    // Lines are sampled on the system clock, edges found by comparison
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 256; i++) begin
                mem[i[7:0]] <= i[7:0] * 8'd29 + 8'h3c;
            end
            ptr        <= 8'd0;
            shift      <= 8'd0;
            out_byte   <= 8'd0;
            bitcnt     <= 4'd0;
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
            selected   <= 1'b0;
            got_addr   <= 1'b0;
            reading    <= 1'b0;
            sending    <= 1'b0;
            first      <= 1'b0;
            master_ack <= 1'b0;
            sda_pull   <= 1'b0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && sda_q && !sda) begin
                // START or repeated START
                selected <= 1'b1;
                got_addr <= 1'b0;
                sending  <= 1'b0;
                first    <= 1'b1;
                bitcnt   <= 4'd0;
                sda_pull <= 1'b0;
            end else if (scl && scl_q && !sda_q && sda) begin
                selected <= 1'b0;   // STOP
                sda_pull <= 1'b0;
            end else if (selected && scl && !scl_q) begin
                bitcnt <= bitcnt + 4'd1;
                if (bitcnt < 4'd8) shift <= {shift[6:0], sda};
                else               master_ack <= !sda;
            end else if (selected && !scl && scl_q) begin
                if (bitcnt == 4'd8) begin
                    if (!got_addr) begin
                        if (shift[7:1] == dev_address) begin
                            got_addr <= 1'b1;
                            reading  <= shift[0];
                            sda_pull <= 1'b1;   // ACK own address
                        end else begin
                            selected <= 1'b0;
                        end
                    end else if (!reading) begin
                        sda_pull <= 1'b1;
                        first    <= 1'b0;
                        if (first) begin
                            ptr <= shift;
                        end else begin
                            mem[ptr] <= shift;
                            ptr      <= ptr + 8'd1;
                        end
                    end else begin
                        sda_pull <= 1'b0;   // Master acknowledges now
                    end
                end else if (bitcnt == 4'd9) begin
                    bitcnt <= 4'd0;
                    if (reading && (!sending || master_ack)) begin
                        out_byte <= mem[ptr];
                        sda_pull <= !mem[ptr][7];
                        ptr      <= ptr + 8'd1;
                        sending  <= 1'b1;
                    end else begin
                        sda_pull <= 1'b0;
                        if (reading) selected <= 1'b0;   // NACK ends the read
                    end
                end else if (sending) begin
                    sda_pull <= !out_byte[3'd7 - bitcnt[2:0]];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_i2c_master.sv ====
//####################################################################
// Testbench for the I2C master
// Random transfers against a target model and a memory reference model
//####################################################################
`default_nettype none

module tb_i2c_master import i2c_pkg::*;;

    localparam int         clk_period     = 20;
    localparam int         num_tests      = 20;
    localparam int         slot_clocks    = 4 * prescaler;
    localparam int         watchdog_time  = 2 * num_tests * 40 * slot_clocks * clk_period;
    localparam logic [6:0] target_address = 7'h50;

    logic        clk;
    logic        reset;
    logic [2:0]  bus_address;
    logic        bus_read;
    logic        bus_write;
    logic [15:0] bus_writedata;
    logic [15:0] bus_readdata;
    logic        irq;
    logic        scl_oe;
    logic        sda_oe;
    logic        sda_pull;
    logic        scl;
    logic        sda;

    logic [7:0]  model_mem [0:255];
    logic [7:0]  model_ptr;
    logic [15:0] exp_rx;       // RXDATA keeps old bytes between reads
    int          seed = 32'hd07e1b7a;
    int          errors;
    int          tests_failed;

    // Open-drain lines
    assign scl = ~scl_oe;
    assign sda = ~(sda_oe | sda_pull);

    i2c_master uut (
        .clk, .reset, .bus_address, .bus_read, .bus_readdata, .bus_write,
        .bus_writedata, .irq, .sda_in(sda), .scl_oe, .sda_oe
    );

    i2c_slave_model target (
        .clk, .reset, .dev_address(target_address), .scl, .sda, .sda_pull
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_time);
        $display("Timeout: transfers did not finish within %0d time units", watchdog_time);
        $display("sim failed");
        $finish;
    end

    task automatic reg_write(input logic [2:0] addr, input logic [15:0] data);
        @(negedge clk);
        bus_address   = addr;
        bus_writedata = data;
        bus_write     = 1'b1;
        @(negedge clk);
        bus_write = 1'b0;
    endtask

    task automatic reg_read(input logic [2:0] addr, output logic [15:0] data);
        @(negedge clk);
        bus_address = addr;
        bus_read    = 1'b1;
        @(negedge clk);
        bus_read = 1'b0;
        data     = bus_readdata;   // Registered one cycle after the read
    endtask

    task automatic report_mismatch(input string name, input logic [15:0] exp,
                                   input logic [15:0] act);
        $display("ERROR %s: expected %h, actual %h", name, exp, act);
        errors++;
    endtask

    task automatic finish_test(input int t, input string desc, input int errors_before);
        if (errors != errors_before) tests_failed++;
        $display("test %0d %s: %s", t, desc, (errors == errors_before) ? "ok" : "FAILED");
    endtask

    task automatic init_model();
        for (int i = 0; i < 256; i++) begin
            model_mem[i[7:0]] = i[7:0] * 8'd29 + 8'h3c;
        end
        model_ptr = 8'd0;
        exp_rx    = 16'h0000;
    endtask

    // Expected effect of one transfer on the target
    task automatic model_transfer(input logic dir, input logic use_iaddr, input logic len2,
                                  input logic [6:0] daddr, input logic [7:0] iaddr,
                                  input logic [15:0] data, output logic exp_ack);
        exp_ack = (daddr == target_address);
        if (!exp_ack) return;   // Address NACK, nothing moves
        if (!dir) begin
            if (use_iaddr) begin
                model_ptr = iaddr;
                model_mem[model_ptr] = data[7:0];
                model_ptr = model_ptr + 8'd1;
            end else begin
                model_ptr = data[7:0];   // First written byte is the pointer
            end
            if (len2) begin
                model_mem[model_ptr] = data[15:8];
                model_ptr = model_ptr + 8'd1;
            end
        end else begin
            if (use_iaddr) model_ptr = iaddr;
            exp_rx[7:0] = model_mem[model_ptr];
            model_ptr   = model_ptr + 8'd1;
            if (len2) begin
                exp_rx[15:8] = model_mem[model_ptr];
                model_ptr    = model_ptr + 8'd1;
            end
        end
    endtask

    task automatic run_transfer(input int t, input logic dir, input logic use_iaddr,
                                input logic len2, input logic [6:0] daddr,
                                input logic [7:0] iaddr, input logic [15:0] data);
        logic [15:0] rdata;
        logic [15:0] ctrl;
        logic        exp_ack;
        int          diffs;
        int          errors_before;
        string       desc;

        errors_before = errors;
        desc = $sformatf("%s len %0d iaddr %0d daddr %h", dir ? "read" : "write",
                         len2 + 1, use_iaddr, daddr);
        model_transfer(dir, use_iaddr, len2, daddr, iaddr, data, exp_ack);

        reg_write(REG_DADDR, {9'd0, daddr});
        reg_write(REG_IADDR, {8'd0, iaddr});
        reg_write(REG_TXDATA, data);
        ctrl = 16'h0000;
        ctrl[ctl_start_bit]  = 1'b1;
        ctrl[ctl_dir_bit]    = dir;
        ctrl[ctl_iaddr_bit]  = use_iaddr;
        ctrl[ctl_length_bit] = len2;
        reg_write(REG_CONTROL, ctrl);

        // Transfer has just started and lasts many slots
        reg_read(REG_STATUS, rdata);
        if (rdata[stat_busy_bit] !== 1'b1) begin
            report_mismatch($sformatf("test %0d BUSY during transfer", t), 16'h0001,
                            {15'd0, rdata[stat_busy_bit]});
        end

        while (irq !== 1'b1) @(negedge clk);   // COMPLETE marks the end of the transfer

        reg_read(REG_STATUS, rdata);
        if (rdata !== {14'd0, exp_ack, 1'b0}) begin
            report_mismatch($sformatf("test %0d STATUS", t), {14'd0, exp_ack, 1'b0}, rdata);
        end
        reg_read(REG_INTFLAG, rdata);
        if (rdata !== 16'h0001) report_mismatch($sformatf("test %0d INTFLAG", t), 16'h0001, rdata);
        reg_read(REG_RXDATA, rdata);
        if (rdata !== exp_rx) report_mismatch($sformatf("test %0d RXDATA", t), exp_rx, rdata);
        if ({scl_oe, sda_oe} !== 2'b00) begin
            report_mismatch($sformatf("test %0d bus lines", t), 16'h0000,
                            {14'd0, scl_oe, sda_oe});
        end

        diffs = 0;
        for (int i = 0; i < 256; i++) begin
            if (target.mem[i[7:0]] !== model_mem[i[7:0]]) diffs++;
        end
        if (diffs != 0) report_mismatch($sformatf("test %0d memory bytes differing", t),
                                        16'h0000, diffs[15:0]);

        // Clear the flag and see the block idle
        reg_write(REG_INTFLAG, 16'h0001);
        reg_read(REG_INTFLAG, rdata);
        if (rdata !== 16'h0000) begin
            report_mismatch($sformatf("test %0d INTFLAG clear", t), 16'h0000, rdata);
        end
        if (irq !== 1'b0) begin
            report_mismatch($sformatf("test %0d irq clear", t), 16'h0000, {15'd0, irq});
        end
        reg_read(REG_STATUS, rdata);
        if (rdata[stat_busy_bit] !== 1'b0) begin
            report_mismatch($sformatf("test %0d BUSY", t), 16'h0000,
                            {15'd0, rdata[stat_busy_bit]});
        end
        finish_test(t, desc, errors_before);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        logic        dir;
        logic        use_iaddr;
        logic        len2;
        logic        wrong;
        logic        readback;
        logic        rb_len2;
        logic [7:0]  rb_iaddr;
        logic [6:0]  daddr;
        logic [7:0]  iaddr;
        logic [15:0] rdata;
        int          errors_before;

        reset         = 1'b1;
        bus_address   = 3'd0;
        bus_read      = 1'b0;
        bus_write     = 1'b0;
        bus_writedata = 16'h0000;
        errors        = 0;
        tests_failed  = 0;
        readback      = 1'b0;
        rb_len2       = 1'b0;
        rb_iaddr      = 8'd0;
        init_model();
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        errors_before = errors;
        reg_read(REG_STATUS, rdata);
        if (rdata !== 16'h0000) report_mismatch("reset STATUS", 16'h0000, rdata);
        reg_read(REG_INTFLAG, rdata);
        if (rdata !== 16'h0000) report_mismatch("reset INTFLAG", 16'h0000, rdata);
        if (irq !== 1'b0) report_mismatch("reset irq", 16'h0000, {15'd0, irq});
        if ({scl_oe, sda_oe} !== 2'b00) begin
            report_mismatch("reset bus lines", 16'h0000, {14'd0, scl_oe, sda_oe});
        end
        finish_test(0, "reset state", errors_before);

        for (int t = 1; t <= num_tests; t++) begin
            r         = $random(seed);
            r2        = $random(seed);
            dir       = r[0];
            use_iaddr = r[1];
            len2      = r[2];
            wrong     = (r[15:8] < 8'd51);   // About one in five
            iaddr     = {4'h0, r[19:16]};    // Small window so reads revisit writes
            if (readback) begin
                // Read back what the last write stored
                dir       = 1'b1;
                use_iaddr = 1'b1;
                len2      = rb_len2;
                iaddr     = rb_iaddr;
                wrong     = 1'b0;
            end
            daddr    = wrong ? (target_address ^ {r[26:21], 1'b1}) : target_address;
            readback = !dir && use_iaddr && !wrong;
            rb_len2  = len2;
            rb_iaddr = iaddr;
            run_transfer(t, dir, use_iaddr, len2, daddr, iaddr, r2[15:0]);
        end

        $display("Tests run %0d, failed %0d, errors %0d", num_tests + 1, tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
i2c_pkg.sv
i2c_regs.sv
i2c_sequencer.sv
i2c_byte_engine.sv
i2c_bit_timer.sv
i2c_master.sv
i2c_slave_model.sv
tb_i2c_master.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the I2C master testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_i2c_master -f filelist.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "^sim passed$" sim.log; then
    exit 0
fi
exit 1
